/* design/lpif_link_pkg.sv */
package lpif_link_pkg;

  //////////////////////////////////////////////////
  // Debug status and delay configuration
  //////////////////////////////////////////////////

  // Online flag positions in both status words
  localparam int DBG_TX_ONLINE_BIT = 19;
  localparam int DBG_RX_ONLINE_BIT = 18;

  // Programmable online and strobe delays
  localparam int DELAY_W = 16;

  //////////////////////////////////////////////////
  // Flit and link beat layout
  //////////////////////////////////////////////////

  // One full-rate flit, 145 bits
  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [7:0]   crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  // Two PHY lanes as seen on the pins
  typedef struct packed {
    logic [79:0] lane1;
    logic [79:0] lane0;
  } link_lanes_t;

  // Same beat split into its fields
  // Flit sits at the bottom of lane0
  typedef struct packed {
    logic [12:0] spare;
    logic        marker;
    logic        strobe;
    lpif_flit_t  flit;
  } link_fields_t;

  // One 160-bit beat, two views
  typedef union packed {
    link_lanes_t  lanes;
    link_fields_t fields;
  } link_beat_u;

endpackage

/* design/link_auto_sync.sv */
module link_auto_sync #(
  parameter int MARKER_WIDTH      = 1,
  parameter bit PERSISTENT_MARKER = 1'b1,
  parameter bit PERSISTENT_STROBE = 1'b1
) (
  input  logic                              clk_wr,
  input  logic                              arst_n,
  input  logic                              tx_online,
  input  logic                              rx_online,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_z_value,
  input  logic                              tx_stb_userbit,
  input  logic [MARKER_WIDTH-1:0]           tx_mrk_userbit,
  output logic                              tx_online_delay,
  output logic                              rx_online_delay,
  output logic                              tx_auto_stb_userbit,
  output logic [MARKER_WIDTH-1:0]           tx_auto_mrk_userbit
);
  import lpif_link_pkg::*;

  // Index 0 is transmit, index 1 is receive
  logic [1:0]         online_in;
  logic [1:0]         online_dly;
  logic [DELAY_W-1:0] dly_val [2];
  logic [DELAY_W-1:0] dly_cnt [2];

  // Strobe spacing
  logic [DELAY_W-1:0] stb_cnt;
  logic               stb_wrap;
  logic               stb_pulse;
  logic               stb_seen;

  //////////////////////////////////////////////////
  // Online delay counters
  //////////////////////////////////////////////////

  assign online_in  = {rx_online, tx_online};
  assign dly_val[0] = delay_x_value;
  assign dly_val[1] = delay_y_value;

  // Count up while online, stop once the delayed level is set
  // Dropping the online level clears both at once
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      online_dly <= '0;
      dly_cnt[0] <= '0;
      dly_cnt[1] <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          dly_cnt[i]    <= '0;
          online_dly[i] <= 1'b0;
        end else if (!online_dly[i]) begin
          dly_cnt[i]    <= dly_cnt[i] + 1'b1;
          online_dly[i] <= (dly_cnt[i] + 1'b1) >= dly_val[i];
        end
      end
    end
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  //////////////////////////////////////////////////
  // Strobe and marker user bits
  //////////////////////////////////////////////////

  // Last count of the period
  assign stb_wrap = (stb_cnt + 1'b1) >= delay_z_value;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt   <= '0;
      stb_pulse <= 1'b0;
      stb_seen  <= 1'b0;
    end else if (!tx_online_delay) begin
      stb_cnt   <= '0;
      stb_pulse <= 1'b0;
      stb_seen  <= 1'b0;
    end else if (stb_wrap) begin
      stb_cnt   <= '0;
      // Single shot unless persistent
      stb_pulse <= PERSISTENT_STROBE || !stb_seen;
      stb_seen  <= 1'b1;
    end else begin
      stb_cnt   <= stb_cnt + 1'b1;
      stb_pulse <= 1'b0;
    end
  end

  assign tx_auto_stb_userbit = stb_pulse | tx_stb_userbit;

  // Marker held high for the whole online period
  assign tx_auto_mrk_userbit =
    tx_mrk_userbit | {MARKER_WIDTH{PERSISTENT_MARKER & tx_online_delay}};

  // Receive side only comes up behind rx_online
  a_rx_dly_follows: assert property (@(posedge clk_wr) disable iff (!arst_n)
    $rose(rx_online_delay) |-> $past(rx_online))
    else $error("rx_online_delay rose while rx_online was low");

endmodule

/* design/lpif_flit_pack.sv */
module lpif_flit_pack (
  input  logic                      clk_wr,
  input  logic                      arst_n,
  // Downstream user fields
  input  logic [3:0]                dstrm_state,
  input  logic [1:0]                dstrm_protid,
  input  logic [127:0]              dstrm_data,
  input  logic                      dstrm_dvalid,
  input  logic [7:0]                dstrm_crc,
  input  logic                      dstrm_crc_valid,
  input  logic                      dstrm_valid,
  // Flits to and from the lane block
  output lpif_link_pkg::lpif_flit_t tx_flit,
  input  lpif_link_pkg::lpif_flit_t rx_flit,
  input  logic                      rx_online_delay,
  // Upstream user fields
  output logic [3:0]                ustrm_state,
  output logic [1:0]                ustrm_protid,
  output logic [127:0]              ustrm_data,
  output logic                      ustrm_dvalid,
  output logic [7:0]                ustrm_crc,
  output logic                      ustrm_crc_valid,
  output logic                      ustrm_valid
);
  import lpif_link_pkg::*;

  lpif_flit_t ustrm_q;
  lpif_flit_t ustrm_flit;

  // Downstream fields into one flit, one cycle
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_flit <= '0;
    end else begin
      tx_flit.state     <= dstrm_state;
      tx_flit.protid    <= dstrm_protid;
      tx_flit.data      <= dstrm_data;
      tx_flit.dvalid    <= dstrm_dvalid;
      tx_flit.crc       <= dstrm_crc;
      tx_flit.crc_valid <= dstrm_crc_valid;
      tx_flit.valid     <= dstrm_valid;
    end
  end

  // Received flit stage
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) ustrm_q <= '0;
    else         ustrm_q <= rx_flit;
  end

  // Nothing goes up while receive is offline
  assign ustrm_flit      = rx_online_delay ? ustrm_q : '0;
  assign ustrm_state     = ustrm_flit.state;
  assign ustrm_protid    = ustrm_flit.protid;
  assign ustrm_data      = ustrm_flit.data;
  assign ustrm_dvalid    = ustrm_flit.dvalid;
  assign ustrm_crc       = ustrm_flit.crc;
  assign ustrm_crc_valid = ustrm_flit.crc_valid;
  assign ustrm_valid     = ustrm_flit.valid;

  // Data valid only inside a valid flit
  a_dvalid_in_flit: assert property (@(posedge clk_wr) disable iff (!arst_n)
    dstrm_dvalid |-> dstrm_valid)
    else $error("dstrm_dvalid without dstrm_valid");

endmodule

/* design/lpif_lane_concat.sv */
module lpif_lane_concat (
  input  logic                      clk_wr,
  input  logic                      arst_n,
  // Transmit side
  input  lpif_link_pkg::lpif_flit_t tx_flit,
  input  logic                      tx_online_delay,
  input  logic                      tx_stb_userbit,
  input  logic                      tx_mrk_userbit,
  output logic [79:0]               tx_phy0,
  output logic [79:0]               tx_phy1,
  // Receive side
  input  logic [79:0]               rx_phy0,
  input  logic [79:0]               rx_phy1,
  output lpif_link_pkg::lpif_flit_t rx_flit
);
  import lpif_link_pkg::*;

  link_beat_u tx_beat_d;
  link_beat_u tx_beat_q;
  link_beat_u rx_beat;

  //////////////////////////////////////////////////
  // Transmit lanes
  //////////////////////////////////////////////////

  // Build the beat from its fields
  always_comb begin
    tx_beat_d.fields.spare  = '0;
    tx_beat_d.fields.marker = tx_mrk_userbit;
    tx_beat_d.fields.strobe = tx_stb_userbit;
    tx_beat_d.fields.flit   = tx_flit;
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) tx_beat_q <= '0;
    else         tx_beat_q <= tx_beat_d;
  end

  // Drive the lane view, quiet while offline
  assign tx_phy0 = tx_online_delay ? tx_beat_q.lanes.lane0 : '0;
  assign tx_phy1 = tx_online_delay ? tx_beat_q.lanes.lane1 : '0;

  //////////////////////////////////////////////////
  // Receive lanes
  //////////////////////////////////////////////////

  // Read the pins as lanes
  always_comb begin
    rx_beat.lanes.lane0 = rx_phy0;
    rx_beat.lanes.lane1 = rx_phy1;
  end

  // Strobe, marker and spare bits are not used on receive
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) rx_flit <= '0;
    else         rx_flit <= rx_beat.fields.flit;
  end

  // Online, lane0 and the low 65 bits of lane1 carry the previous flit
  // Offline, the link stays silent
  a_tx_lanes: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_online_delay ? ({tx_phy1[64:0], tx_phy0} == $past(tx_flit))
                    : (tx_phy0 == '0 && tx_phy1 == '0))
    else $error("transmit lanes do not match the flit and online level");

endmodule

/* design/lpif_link_top.sv */
module lpif_link_top #(
  parameter int MARKER_WIDTH      = 1,
  parameter bit PERSISTENT_MARKER = 1'b1,
  parameter bit PERSISTENT_STROBE = 1'b1
) (
  input  logic                              clk_wr,
  input  logic                              arst_n,
  // Online levels
  input  logic                              tx_online,
  input  logic                              rx_online,
  // PHY lanes
  output logic [79:0]                       tx_phy0,
  input  logic [79:0]                       rx_phy0,
  output logic [79:0]                       tx_phy1,
  input  logic [79:0]                       rx_phy1,
  // Downstream channel
  input  logic [3:0]                        dstrm_state,
  input  logic [1:0]                        dstrm_protid,
  input  logic [127:0]                      dstrm_data,
  input  logic                              dstrm_dvalid,
  input  logic [7:0]                        dstrm_crc,
  input  logic                              dstrm_crc_valid,
  input  logic                              dstrm_valid,
  // Upstream channel
  output logic [3:0]                        ustrm_state,
  output logic [1:0]                        ustrm_protid,
  output logic [127:0]                      ustrm_data,
  output logic                              ustrm_dvalid,
  output logic [7:0]                        ustrm_crc,
  output logic                              ustrm_crc_valid,
  output logic                              ustrm_valid,
  // Debug status
  output logic [31:0]                       tx_downstream_debug_status,
  output logic [31:0]                       rx_upstream_debug_status,
  // User bits and delays
  input  logic [MARKER_WIDTH-1:0]           tx_mrk_userbit,
  input  logic                              tx_stb_userbit,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [lpif_link_pkg::DELAY_W-1:0] delay_z_value
);
  import lpif_link_pkg::*;

  lpif_flit_t              tx_flit;
  lpif_flit_t              rx_flit;
  logic                    tx_online_delay;
  logic                    rx_online_delay;
  logic                    tx_auto_stb_userbit;
  logic [MARKER_WIDTH-1:0] tx_auto_mrk_userbit;
  logic [31:0]             status_word;

  link_auto_sync #(
    .MARKER_WIDTH      (MARKER_WIDTH),
    .PERSISTENT_MARKER (PERSISTENT_MARKER),
    .PERSISTENT_STROBE (PERSISTENT_STROBE)
  ) u_auto_sync (
    .clk_wr              (clk_wr),
    .arst_n              (arst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  lpif_flit_pack u_flit_pack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .rx_online_delay (rx_online_delay),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  // Lane format has a single marker bit
  lpif_lane_concat u_lane_concat (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_flit         (tx_flit),
    .tx_online_delay (tx_online_delay),
    .tx_stb_userbit  (tx_auto_stb_userbit),
    .tx_mrk_userbit  (|tx_auto_mrk_userbit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_flit         (rx_flit)
  );

  // Same word on both sides, only the online flags
  always_comb begin
    status_word                    = '0;
    status_word[DBG_TX_ONLINE_BIT] = tx_online_delay;
    status_word[DBG_RX_ONLINE_BIT] = rx_online_delay;
  end

  assign tx_downstream_debug_status = status_word;
  assign rx_upstream_debug_status   = status_word;

endmodule

/* tb/lpif_link_tb.sv */
module lpif_link_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import lpif_link_pkg::*;

  // Tests need under 200 cycles, wide margin on top
  localparam int MAX_CYCLES = 2000;
  localparam int DRIVE_DLY  = 2;
  localparam int NUM_FLITS  = 50;

  logic               clk_wr = 1'b0;
  logic               arst_n;
  logic               tx_online;
  logic               rx_online;
  logic [79:0]        tx_phy0;
  logic [79:0]        tx_phy1;
  logic [3:0]         dstrm_state;
  logic [1:0]         dstrm_protid;
  logic [127:0]       dstrm_data;
  logic               dstrm_dvalid;
  logic [7:0]         dstrm_crc;
  logic               dstrm_crc_valid;
  logic               dstrm_valid;
  logic [3:0]         ustrm_state;
  logic [1:0]         ustrm_protid;
  logic [127:0]       ustrm_data;
  logic               ustrm_dvalid;
  logic [7:0]         ustrm_crc;
  logic               ustrm_crc_valid;
  logic               ustrm_valid;
  logic [31:0]        tx_downstream_debug_status;
  logic [31:0]        rx_upstream_debug_status;
  logic               tx_mrk_userbit;
  logic               tx_stb_userbit;
  logic [DELAY_W-1:0] delay_x_value;
  logic [DELAY_W-1:0] delay_y_value;
  logic [DELAY_W-1:0] delay_z_value;

  lpif_flit_t  ustrm_seen;
  logic [31:0] rng_state = 32'h457d;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count;

  // 20 ns clock
  always #10 clk_wr = ~clk_wr;

  // Loopback, transmit lanes straight into receive
  lpif_link_top dut (
    .clk_wr, .arst_n, .tx_online, .rx_online,
    .tx_phy0, .rx_phy0 (tx_phy0), .tx_phy1, .rx_phy1 (tx_phy1),
    .dstrm_state, .dstrm_protid, .dstrm_data, .dstrm_dvalid,
    .dstrm_crc, .dstrm_crc_valid, .dstrm_valid,
    .ustrm_state, .ustrm_protid, .ustrm_data, .ustrm_dvalid,
    .ustrm_crc, .ustrm_crc_valid, .ustrm_valid,
    .tx_downstream_debug_status, .rx_upstream_debug_status,
    .tx_mrk_userbit, .tx_stb_userbit,
    .delay_x_value, .delay_y_value, .delay_z_value
  );

  // Upstream fields gathered back into a flit
  assign ustrm_seen = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                       ustrm_crc, ustrm_crc_valid, ustrm_valid};

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // xorshift32, advances the shared state
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // dvalid only ever set inside a valid flit
  function automatic lpif_flit_t random_flit();
    lpif_flit_t  f;
    logic [31:0] r;
    r           = xorshift32();
    f.state     = r[3:0];
    f.protid    = r[5:4];
    f.crc       = r[13:6];
    f.valid     = r[14];
    f.dvalid    = r[14] & r[15];
    f.crc_valid = r[16];
    for (int i = 0; i < 4; i++) begin
      f.data[32*i +: 32] = xorshift32();
    end
    return f;
  endfunction

  task automatic drive_flit(input lpif_flit_t f);
    dstrm_state     = f.state;
    dstrm_protid    = f.protid;
    dstrm_data      = f.data;
    dstrm_dvalid    = f.dvalid;
    dstrm_crc       = f.crc;
    dstrm_crc_valid = f.crc_valid;
    dstrm_valid     = f.valid;
  endtask

  // Land just after the edge, outputs settled
  task automatic next_cycle();
    @(posedge clk_wr);
    #DRIVE_DLY;
  endtask

  // Both online flags up, bounded by the timeout
  task automatic wait_link_up();
    while (!(tx_downstream_debug_status[DBG_TX_ONLINE_BIT] &&
             rx_upstream_debug_status[DBG_RX_ONLINE_BIT])) begin
      next_cycle();
    end
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_flit(input string name, input lpif_flit_t exp, input lpif_flit_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_lanes(input string name, input link_lanes_t exp,
                             input link_lanes_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    check_lanes("reset lanes", '0, {tx_phy1, tx_phy0});
    check_bit("reset ustrm_valid", 1'b0, ustrm_valid);
    check_status("reset tx status", '0, tx_downstream_debug_status);
    check_status("reset rx status", '0, rx_upstream_debug_status);
  endtask

  // Flags rise exactly x and y cycles after the online levels
  task automatic test_online_delay();
    logic [31:0] exp;
    tx_online = 1'b1;
    rx_online = 1'b1;
    for (int k = 1; k <= 9; k++) begin
      next_cycle();
      exp                    = '0;
      exp[DBG_TX_ONLINE_BIT] = (k >= int'(delay_x_value));
      exp[DBG_RX_ONLINE_BIT] = (k >= int'(delay_y_value));
      check_status("online_delay tx status", exp, tx_downstream_debug_status);
      check_status("online_delay rx status", exp, rx_upstream_debug_status);
    end
    tx_online = 1'b0;
    rx_online = 1'b0;
    next_cycle();
    check_status("online_delay tx drop", '0, tx_downstream_debug_status);
    check_status("online_delay rx drop", '0, rx_upstream_debug_status);
  endtask

  // Two stages out, two stages back
  task automatic test_loopback();
    lpif_flit_t sent [NUM_FLITS];
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_link_up();
    for (int k = 0; k < NUM_FLITS + 3; k++) begin
      if (k < NUM_FLITS) begin
        sent[k] = random_flit();
        drive_flit(sent[k]);
      end else begin
        drive_flit('0);
      end
      next_cycle();
      if (k >= 3) check_flit("loopback", sent[k-3], ustrm_seen);
    end
  endtask

  // Strobe phase taken from its first pulse
  task automatic test_strobe_marker();
    link_beat_u beat;
    int         first;
    int         period;
    period = int'(delay_z_value);
    first  = -1;
    for (int c = 0; c < 6 * period; c++) begin
      next_cycle();
      beat.lanes.lane0 = tx_phy0;
      beat.lanes.lane1 = tx_phy1;
      check_bit("strobe_marker marker", 1'b1, beat.fields.marker);
      if (first >= 0) begin
        check_bit("strobe_marker strobe", ((c - first) % period) == 0, beat.fields.strobe);
      end else if (beat.fields.strobe) begin
        first = c;
      end
    end
    if (first < 0 || first >= period) begin
      other_errors++;
      $display("ERROR: strobe bit did not pulse within the first strobe period");
    end
  endtask

  task automatic test_offline_gating();
    rx_online = 1'b0;
    next_cycle();
    check_bit("offline rx flag", 1'b0, rx_upstream_debug_status[DBG_RX_ONLINE_BIT]);
    for (int k = 0; k < 20; k++) begin
      drive_flit(random_flit());
      next_cycle();
      check_flit("offline ustrm", '0, ustrm_seen);
    end
    tx_online = 1'b0;
    dstrm_dvalid = 1'b0;
    next_cycle();
    for (int k = 0; k < 20; k++) begin
      dstrm_valid = ~dstrm_valid;
      next_cycle();
      check_lanes("offline tx_phy", '0, {tx_phy1, tx_phy0});
    end
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_wr);
      cycle_count++;
    end
    $display("ERROR: run stopped at the %0d cycle limit", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = 1'b0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = 16'd5;
    delay_y_value  = 16'd7;
    delay_z_value  = 16'd8;
    drive_flit('0);
    repeat (10) @(posedge clk_wr);
    #DRIVE_DLY;
    arst_n = 1'b1;
    test_reset();
    next_cycle();
    test_reset();
    test_online_delay();
    test_loopback();
    test_strobe_marker();
    test_offline_gating();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
design/lpif_link_pkg.sv
design/link_auto_sync.sv
design/lpif_flit_pack.sv
design/lpif_lane_concat.sv
design/lpif_link_top.sv
tb/lpif_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LPIF link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module lpif_link_tb \
  -Mdir obj_dir \
  -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vlpif_link_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0
